/* Bender.yml */
package:
  name: fb_draw

sources:
  - include_dirs:
      - .
    files:
      - fb_pkg.sv
      - fb_fill.sv
      - fb_writer.sv
      - fb_sram_axil.sv
      - fb_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - fb_top_sva.sv
      - tb_fb_top.sv

/* fb_fill.sv */
`include "fb_macros.svh"

module fb_fill (
  input  logic              clk,
  input  logic              rst,

  // draw command, accepted only while idle
  input  logic              cmd_valid,
  output logic              cmd_ready,
  input  fb_pkg::x_t        cmd_x0,
  input  fb_pkg::y_t        cmd_y0,
  input  fb_pkg::x_t        cmd_x1,
  input  fb_pkg::y_t        cmd_y1,
  input  fb_pkg::pixel_t    cmd_color,
  output logic              busy,

  // pixel stream towards the axi writer
  output logic              axi_tvalid,
  input  logic              axi_tready,
  output fb_pkg::axi_addr_t addr,
  output fb_pkg::pixel_t    color
);

  fb_pkg::fill_state_t state;
  logic                tvalid_q;

  // latched command corners and colour
  fb_pkg::x_t     x0_q;
  fb_pkg::y_t     y0_q;
  fb_pkg::x_t     x1_q;
  fb_pkg::y_t     y1_q;
  fb_pkg::pixel_t color_q;

  // current pixel position
  fb_pkg::x_t cur_x;
  fb_pkg::y_t cur_y;

  fb_pkg::axi_addr_t pix_index;
  logic              cmd_fire;
  logic              pix_fire;
  logic              empty_rect;
  logic              row_end;
  logic              last_pix;

  assign cmd_ready = (state == fb_pkg::FILL_IDLE);
  assign busy      = (state == fb_pkg::FILL_RUN);
  assign cmd_fire  = cmd_valid && cmd_ready;
  assign pix_fire  = tvalid_q && axi_tready;

  // inverted corners on either axis give no pixels at all
  assign empty_rect = (x1_q < x0_q) || (y1_q < y0_q);
  assign row_end    = (cur_x == x1_q);
  assign last_pix   = row_end && (cur_y == y1_q);

  // byte address is twice the row-major pixel index
  assign pix_index  = fb_pkg::axi_addr_t'(cur_y) * fb_pkg::axi_addr_t'(`FB_WIDTH)
                      + fb_pkg::axi_addr_t'(cur_x);
  assign addr       = {pix_index[`FB_AXI_ADDR_WIDTH-2:0], 1'b0};
  assign color      = color_q;
  assign axi_tvalid = tvalid_q;

  // control: idle -> run on a command, back to idle after the last pixel
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= fb_pkg::FILL_IDLE;
      tvalid_q <= 1'b0;
    end else begin
      case (state)
        fb_pkg::FILL_IDLE: begin
          if (cmd_fire) begin
            state <= fb_pkg::FILL_RUN;
          end
        end
        fb_pkg::FILL_RUN: begin
          if (!tvalid_q) begin
            // first cycle after accept, corners are now registered
            if (empty_rect) begin
              state <= fb_pkg::FILL_IDLE;
            end else begin
              tvalid_q <= 1'b1;
            end
          end else if (pix_fire && last_pix) begin
            state    <= fb_pkg::FILL_IDLE;
            tvalid_q <= 1'b0;
          end
        end
        default: begin
          state    <= fb_pkg::FILL_IDLE;
          tvalid_q <= 1'b0;
        end
      endcase
    end
  end

  // payload: command latch and the row-major walk
  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      x0_q    <= cmd_x0;
      y0_q    <= cmd_y0;
      x1_q    <= cmd_x1;
      y1_q    <= cmd_y1;
      color_q <= cmd_color;
      cur_x   <= cmd_x0;
      cur_y   <= cmd_y0;
    end else if (pix_fire && !last_pix) begin
      if (row_end) begin
        // wrap to the start of the next row
        cur_x <= x0_q;
        cur_y <= fb_pkg::y_t'(cur_y + 1'b1);
      end else begin
        cur_x <= fb_pkg::x_t'(cur_x + 1'b1);
      end
    end
  end

endmodule

/* fb_macros.svh */
`ifndef FB_MACROS_SVH
`define FB_MACROS_SVH

// colour bits per pixel, packed into the top of a data word
`define FB_PIXEL_BITS 12

// axi-lite byte address and data widths
`define FB_AXI_ADDR_WIDTH 20
`define FB_AXI_DATA_WIDTH 16

// frame size in pixels and the coordinate widths that cover it
`define FB_WIDTH 16
`define FB_HEIGHT 8
`define FB_X_BITS 4
`define FB_Y_BITS 3

// one storage word per pixel
`define FB_DEPTH (`FB_WIDTH * `FB_HEIGHT)

`endif

/* fb_pkg.sv */
`include "fb_macros.svh"

package fb_pkg;

  // pixel colour and frame coordinates
  typedef logic [`FB_PIXEL_BITS-1:0] pixel_t;
  typedef logic [`FB_X_BITS-1:0] x_t;
  typedef logic [`FB_Y_BITS-1:0] y_t;

  // axi-lite payload types
  typedef logic [`FB_AXI_ADDR_WIDTH-1:0] axi_addr_t;
  typedef logic [`FB_AXI_DATA_WIDTH-1:0] axi_data_t;
  typedef logic [`FB_AXI_DATA_WIDTH/8-1:0] axi_strb_t;
  typedef logic [1:0] axi_resp_t;

  // response codes used by the sram slave
  localparam axi_resp_t RESP_OKAY = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10;

  // rectangle fill engine states
  typedef enum logic {
    FILL_IDLE,
    FILL_RUN
  } fill_state_t;

endpackage

/* fb_sram_axil.sv */
`include "fb_macros.svh"

module fb_sram_axil (
  input  logic              clk,
  input  logic              rst,

  // write address and data, raised together by the master
  input  fb_pkg::axi_addr_t awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  fb_pkg::axi_data_t wdata,
  input  fb_pkg::axi_strb_t wstrb,
  input  logic              wvalid,
  output logic              wready,

  // write response
  output logic              bvalid,
  input  logic              bready,
  output fb_pkg::axi_resp_t bresp,

  // read address and data
  input  fb_pkg::axi_addr_t araddr,
  input  logic              arvalid,
  output logic              arready,
  output fb_pkg::axi_data_t rdata,
  output fb_pkg::axi_resp_t rresp,
  output logic              rvalid,
  input  logic              rready
);

  localparam int IDX_BITS = $clog2(`FB_DEPTH);
  localparam int STRB_BITS = `FB_AXI_DATA_WIDTH / 8;

  // frame buffer, one word per pixel
  fb_pkg::axi_data_t mem [`FB_DEPTH];

  // word index is the byte address without its lowest bit
  logic [`FB_AXI_ADDR_WIDTH-2:0] wr_word;
  logic [`FB_AXI_ADDR_WIDTH-2:0] rd_word;
  logic                          wr_in_range;
  logic                          rd_in_range;
  logic                          wr_ready;
  logic                          wr_fire;
  logic                          rd_fire;

  assign wr_word     = awaddr[`FB_AXI_ADDR_WIDTH-1:1];
  assign rd_word     = araddr[`FB_AXI_ADDR_WIDTH-1:1];
  assign wr_in_range = (wr_word < `FB_DEPTH);
  assign rd_in_range = (rd_word < `FB_DEPTH);

  // reads own the single storage port whenever one is requested
  // and writes also wait while the previous response is stuck
  assign wr_ready = (!bvalid || bready) && !arvalid;
  assign awready  = wr_ready;
  assign wready   = wr_ready;
  assign wr_fire  = awvalid && wvalid && wr_ready;

  // a new read can be taken once the old response leaves
  assign arready = !rvalid || rready;
  assign rd_fire = arvalid && arready;

  // storage write with per-byte strobes, out-of-range beats are dropped
  always_ff @(posedge clk) begin
    if (wr_fire && wr_in_range) begin
      for (int b = 0; b < STRB_BITS; b++) begin
        if (wstrb[b]) begin
          mem[wr_word[IDX_BITS-1:0]][b*8 +: 8] <= wdata[b*8 +: 8];
        end
      end
    end
  end

  // write response handshake
  always_ff @(posedge clk) begin
    if (rst) begin
      bvalid <= 1'b0;
    end else if (wr_fire) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      bresp <= wr_in_range ? fb_pkg::RESP_OKAY : fb_pkg::RESP_SLVERR;
    end
  end

  // read response handshake
  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid <= 1'b0;
    end else if (rd_fire) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  // read data, zero on a bad address
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      if (rd_in_range) begin
        rdata <= mem[rd_word[IDX_BITS-1:0]];
        rresp <= fb_pkg::RESP_OKAY;
      end else begin
        rdata <= '0;
        rresp <= fb_pkg::RESP_SLVERR;
      end
    end
  end

endmodule

/* fb_top.sv */
module fb_top (
  input  logic              clk,
  input  logic              rst,

  // draw command port
  input  logic              cmd_valid,
  output logic              cmd_ready,
  input  fb_pkg::x_t        cmd_x0,
  input  fb_pkg::y_t        cmd_y0,
  input  fb_pkg::x_t        cmd_x1,
  input  fb_pkg::y_t        cmd_y1,
  input  fb_pkg::pixel_t    cmd_color,
  output logic              busy,

  // external axi-lite read port into the frame buffer
  input  fb_pkg::axi_addr_t araddr,
  input  logic              arvalid,
  output logic              arready,
  output fb_pkg::axi_data_t rdata,
  output fb_pkg::axi_resp_t rresp,
  output logic              rvalid,
  input  logic              rready
);

  // pixel stream, fill engine to writer
  logic              pix_tvalid;
  logic              pix_tready;
  fb_pkg::axi_addr_t pix_addr;
  fb_pkg::pixel_t    pix_color;

  // axi-lite write, writer to sram
  fb_pkg::axi_addr_t awaddr;
  logic              awvalid;
  logic              awready;
  fb_pkg::axi_data_t wdata;
  fb_pkg::axi_strb_t wstrb;
  logic              wvalid;
  logic              wready;
  logic              bvalid;
  logic              bready;
  fb_pkg::axi_resp_t bresp;

  fb_fill i_fb_fill (
    .clk        (clk),
    .rst        (rst),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .cmd_x0     (cmd_x0),
    .cmd_y0     (cmd_y0),
    .cmd_x1     (cmd_x1),
    .cmd_y1     (cmd_y1),
    .cmd_color  (cmd_color),
    .busy       (busy),
    .axi_tvalid (pix_tvalid),
    .axi_tready (pix_tready),
    .addr       (pix_addr),
    .color      (pix_color)
  );

  fb_writer i_fb_writer (
    .clk              (clk),
    .rst              (rst),
    .axi_tvalid       (pix_tvalid),
    .axi_tready       (pix_tready),
    .addr             (pix_addr),
    .color            (pix_color),
    .sram_axi_awaddr  (awaddr),
    .sram_axi_awvalid (awvalid),
    .sram_axi_awready (awready),
    .sram_axi_wdata   (wdata),
    .sram_axi_wstrb   (wstrb),
    .sram_axi_wvalid  (wvalid),
    .sram_axi_wready  (wready),
    .sram_axi_bready  (bready),
    .sram_axi_bvalid  (bvalid),
    .sram_axi_bresp   (bresp)
  );

  fb_sram_axil i_fb_sram_axil (
    .clk     (clk),
    .rst     (rst),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready)
  );

endmodule

/* fb_top_sva.sv */
module fb_top_sva (
  input logic              clk,
  input logic              rst,
  input logic              pix_tvalid,
  input logic              pix_tready,
  input fb_pkg::axi_addr_t pix_addr,
  input fb_pkg::pixel_t    pix_color,
  input logic              awvalid,
  input logic              awready,
  input fb_pkg::axi_addr_t awaddr,
  input logic              wvalid,
  input logic              wready,
  input fb_pkg::axi_data_t wdata,
  input logic              bvalid,
  input fb_pkg::axi_resp_t bresp,
  input logic              rvalid,
  input logic              rready,
  input fb_pkg::axi_data_t rdata,
  input fb_pkg::axi_resp_t rresp,
  input logic              cmd_ready,
  input logic              busy
);

  // count of failed assertions
  int unsigned fail_count = 0;

  // a stalled pixel keeps its address and colour
  stream_hold: assert property (@(posedge clk) disable iff (rst)
    pix_tvalid && !pix_tready |=> pix_tvalid && $stable(pix_addr) && $stable(pix_color))
    else begin
      fail_count++;
      $error("pixel stream changed before it was accepted");
    end

  // aw and w complete together and hold until both readies are high
  write_hold: assert property (@(posedge clk) disable iff (rst)
    awvalid && !(awready && wready) |=> awvalid && $stable(awaddr) && $stable(wdata))
    else begin
      fail_count++;
      $error("write beat changed before it was accepted");
    end

  read_hold: assert property (@(posedge clk) disable iff (rst)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else begin
      fail_count++;
      $error("read response changed before it was accepted");
    end

  // every pixel lands inside the frame and is answered on the next edge
  write_answered: assert property (@(posedge clk) disable iff (rst)
    awvalid && wvalid && awready && wready |=> bvalid && bresp == fb_pkg::RESP_OKAY)
    else begin
      fail_count++;
      $error("paired write beat not answered with okay");
    end

  // an idle engine has no pixel on the stream
  idle_not_busy: assert property (@(posedge clk) disable iff (rst)
    cmd_ready |-> !busy && !pix_tvalid)
    else begin
      fail_count++;
      $error("busy or pixel valid high while the engine takes commands");
    end

endmodule

bind fb_top fb_top_sva i_fb_top_sva (
  .clk        (clk),
  .rst        (rst),
  .pix_tvalid (pix_tvalid),
  .pix_tready (pix_tready),
  .pix_addr   (pix_addr),
  .pix_color  (pix_color),
  .awvalid    (awvalid),
  .awready    (awready),
  .awaddr     (awaddr),
  .wvalid     (wvalid),
  .wready     (wready),
  .wdata      (wdata),
  .bvalid     (bvalid),
  .bresp      (bresp),
  .rvalid     (rvalid),
  .rready     (rready),
  .rdata      (rdata),
  .rresp      (rresp),
  .cmd_ready  (cmd_ready),
  .busy       (busy)
);

/* fb_writer.sv */
`include "fb_macros.svh"

// turns the pixel stream straight into axi-lite write beats
module fb_writer (
  // unused, kept so the writer can grow state later without a port change
  input  logic              clk,
  input  logic              rst,

  // pixel stream handshake and payload
  input  logic              axi_tvalid,
  output logic              axi_tready,
  input  fb_pkg::axi_addr_t addr,
  input  fb_pkg::pixel_t    color,

  // axi-lite write master towards the frame buffer
  output fb_pkg::axi_addr_t sram_axi_awaddr,
  output logic              sram_axi_awvalid,
  input  logic              sram_axi_awready,
  output fb_pkg::axi_data_t sram_axi_wdata,
  output fb_pkg::axi_strb_t sram_axi_wstrb,
  output logic              sram_axi_wvalid,
  input  logic              sram_axi_wready,
  output logic              sram_axi_bready,
  // the write response is not looked at
  input  logic              sram_axi_bvalid,
  input  fb_pkg::axi_resp_t sram_axi_bresp
);

  // address and data go out together on one stream beat
  assign sram_axi_awvalid = axi_tvalid;
  assign sram_axi_awaddr  = addr;
  assign sram_axi_wvalid  = axi_tvalid;

  // colour in the top bits, low bits zero
  assign sram_axi_wdata = {color, {(`FB_AXI_DATA_WIDTH - `FB_PIXEL_BITS){1'b0}}};

  // full word write every time
  assign sram_axi_wstrb = '1;

  // responses are always drained
  assign sram_axi_bready = 1'b1;

  // a beat completes only when both channels take it in the same cycle
  assign axi_tready = sram_axi_awready & sram_axi_wready;

endmodule

/* sources.f */
+incdir+.
fb_pkg.sv
fb_fill.sv
fb_writer.sv
fb_sram_axil.sv
fb_top.sv
fb_top_sva.sv
tb_fb_top.sv

/* tb_fb_top.sv */
`include "fb_macros.svh"

module tb_fb_top;

  localparam int NUM_ROWS = 10;
  localparam int CMD_TIMEOUT = 50;
  localparam int IDLE_TIMEOUT = 600;
  localparam int READ_TIMEOUT = 20;

  // one draw command plus the concurrent-read and full-readback flags
  typedef struct packed {
    fb_pkg::x_t     x0;
    fb_pkg::y_t     y0;
    fb_pkg::x_t     x1;
    fb_pkg::y_t     y1;
    fb_pkg::pixel_t color;
    logic           reads;
    logic           readback;
  } row_t;

  // first row paints the whole frame so the shadow starts fully known
  localparam row_t ROWS [NUM_ROWS] = '{
    '{4'd0,  3'd0, 4'd15, 3'd7, 12'h123, 1'b0, 1'b1},
    '{4'd5,  3'd3, 4'd5,  3'd3, 12'habc, 1'b0, 1'b1},
    '{4'd2,  3'd1, 4'd9,  3'd5, 12'h5a5, 1'b0, 1'b0},
    '{4'd6,  3'd0, 4'd13, 3'd3, 12'h0f0, 1'b0, 1'b0},
    '{4'd0,  3'd4, 4'd7,  3'd7, 12'h9c3, 1'b0, 1'b1},
    '{4'd10, 3'd2, 4'd4,  3'd6, 12'hfff, 1'b0, 1'b1},
    '{4'd1,  3'd1, 4'd14, 3'd6, 12'h3e7, 1'b1, 1'b1},
    '{4'd0,  3'd0, 4'd15, 3'd7, 12'h842, 1'b1, 1'b1},
    '{4'd3,  3'd5, 4'd8,  3'd2, 12'h111, 1'b0, 1'b1},
    '{4'd4,  3'd0, 4'd11, 3'd7, 12'hd1c, 1'b1, 1'b1}
  };

  logic              clk;
  logic              rst;
  logic              cmd_valid;
  logic              cmd_ready;
  fb_pkg::x_t        cmd_x0;
  fb_pkg::y_t        cmd_y0;
  fb_pkg::x_t        cmd_x1;
  fb_pkg::y_t        cmd_y1;
  fb_pkg::pixel_t    cmd_color;
  logic              busy;
  fb_pkg::axi_addr_t araddr;
  logic              arvalid;
  logic              arready;
  fb_pkg::axi_data_t rdata;
  fb_pkg::axi_resp_t rresp;
  logic              rvalid;
  logic              rready;

  // expected frame contents
  fb_pkg::axi_data_t shadow [`FB_DEPTH];
  integer            seed;

  fb_top i_fb_top (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_x0    (cmd_x0),
    .cmd_y0    (cmd_y0),
    .cmd_x1    (cmd_x1),
    .cmd_y1    (cmd_y1),
    .cmd_color (cmd_color),
    .busy      (busy),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // watches the bound checker
  initial begin
    wait (i_fb_top.i_fb_top_sva.fail_count != 0);
    $display("a bound assertion failed at %0t", $time);
    $display("Verification failed");
    $fatal(1, "assertion failure");
  end

  task automatic check_data(input string name, input fb_pkg::axi_data_t exp,
                            input fb_pkg::axi_data_t act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      $display("Verification failed");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_resp(input string name, input fb_pkg::axi_resp_t exp,
                            input fb_pkg::axi_resp_t act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      $display("Verification failed");
      $fatal(1, "response mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
      $display("Verification failed");
      $fatal(1, "control mismatch");
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("timeout at %0t: %s", $time, what);
    $display("Verification failed");
    $fatal(1, "wait timed out");
  endtask

  // byte address of a pixel in row-major order with two bytes per word
  function automatic fb_pkg::axi_addr_t pixel_addr(input int x, input int y);
    return fb_pkg::axi_addr_t'((y * `FB_WIDTH + x) * 2);
  endfunction

  // later commands overwrite earlier ones and inverted corners paint nothing
  task automatic paint_shadow(input row_t r);
    for (int y = int'(r.y0); y <= int'(r.y1); y++) begin
      for (int x = int'(r.x0); x <= int'(r.x1); x++) begin
        shadow[y * `FB_WIDTH + x] = {r.color, 4'h0};
      end
    end
  endtask

  task automatic send_cmd(input row_t r);
    int n;
    @(negedge clk);
    cmd_valid = 1'b1;
    cmd_x0    = r.x0;
    cmd_y0    = r.y0;
    cmd_x1    = r.x1;
    cmd_y1    = r.y1;
    cmd_color = r.color;
    n = 0;
    // cmd_ready seen high here means the next rising edge takes the command
    while (!cmd_ready) begin
      if (n == CMD_TIMEOUT) fail_timeout("the fill engine never accepted a draw command");
      @(negedge clk);
      n++;
    end
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy) begin
      if (n == IDLE_TIMEOUT) fail_timeout("busy did not fall after a draw command");
      @(negedge clk);
      n++;
    end
    check_bit("cmd_ready", 1'b1, cmd_ready);
  endtask

  task automatic read_word(input fb_pkg::axi_addr_t a, output fb_pkg::axi_data_t d,
                           output fb_pkg::axi_resp_t r);
    int n;
    @(negedge clk);
    araddr  = a;
    arvalid = 1'b1;
    n = 0;
    while (!arready) begin
      if (n == READ_TIMEOUT) fail_timeout("arready did not rise for a read");
      @(negedge clk);
      n++;
    end
    @(negedge clk);
    arvalid = 1'b0;
    n = 0;
    while (!rvalid) begin
      if (n == READ_TIMEOUT) fail_timeout("rvalid did not rise after an accepted read");
      @(negedge clk);
      n++;
    end
    // response held one extra edge with rready low
    check_bit("arready", 1'b0, arready);
    @(negedge clk);
    check_bit("rvalid", 1'b1, rvalid);
    d = rdata;
    r = rresp;
    // response leaves on the next edge
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic readback_all();
    fb_pkg::axi_data_t d;
    fb_pkg::axi_resp_t r;
    for (int i = 0; i < `FB_DEPTH; i++) begin
      read_word(fb_pkg::axi_addr_t'(i * 2), d, r);
      check_resp($sformatf("rresp[%0d]", i), fb_pkg::RESP_OKAY, r);
      check_data($sformatf("rdata[%0d]", i), shadow[i], d);
    end
  endtask

  // random reads during a fill steal one write cycle each
  task automatic reads_while_busy();
    fb_pkg::axi_data_t d;
    fb_pkg::axi_resp_t r;
    int                idx;
    int                n;
    n = 0;
    while (busy) begin
      if (n == IDLE_TIMEOUT) fail_timeout("busy stayed high during concurrent reads");
      idx = $unsigned($random(seed)) % `FB_DEPTH;
      read_word(fb_pkg::axi_addr_t'(idx * 2), d, r);
      check_resp("rresp", fb_pkg::RESP_OKAY, r);
      n++;
    end
  endtask

  initial begin
    fb_pkg::axi_data_t d;
    fb_pkg::axi_resp_t r;
    seed      = 32'h9da871b1;
    rst       = 1'b1;
    cmd_valid = 1'b0;
    cmd_x0    = '0;
    cmd_y0    = '0;
    cmd_x1    = '0;
    cmd_y1    = '0;
    cmd_color = '0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    repeat (3) @(negedge clk);
    rst = 1'b0;

    // idle outputs straight after reset
    check_bit("cmd_ready", 1'b1, cmd_ready);
    check_bit("busy", 1'b0, busy);
    check_bit("rvalid", 1'b0, rvalid);
    check_bit("arready", 1'b1, arready);

    for (int i = 0; i < NUM_ROWS; i++) begin
      send_cmd(ROWS[i]);
      if (ROWS[i].reads) reads_while_busy();
      wait_idle();
      paint_shadow(ROWS[i]);
      // single pixel holds the colour in bits 15 to 4
      if (ROWS[i].x0 == ROWS[i].x1 && ROWS[i].y0 == ROWS[i].y1) begin
        read_word(pixel_addr(ROWS[i].x0, ROWS[i].y0), d, r);
        check_resp("rresp", fb_pkg::RESP_OKAY, r);
        check_data("rdata", {ROWS[i].color, 4'h0}, d);
      end
      if (ROWS[i].readback) readback_all();
    end

    // first word past the frame
    read_word(fb_pkg::axi_addr_t'(`FB_DEPTH * 2), d, r);
    check_resp("rresp", fb_pkg::RESP_SLVERR, r);
    check_data("rdata", '0, d);

    $display("Verification passed");
    $finish;
  end

endmodule
